// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := lsu_tb
FILELIST   := filelist.f
BUILD_DIR  := obj_dir
VFLAGS     := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing --assert -Wall
RUN_FLAGS  := +verilator+error+limit+1000
PASS_MSG   := Regression passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== dv/lsu_checker.sv ====
//////////////////////////////
// bus protocol assertions for lsu_top, attached with bind
// checks are off while rst_ni is low
// fail_count holds the number of failed assertions
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module lsu_checker (
  input logic                clk_i,
  input logic                rst_ni,
  input logic                data_req_o,
  input logic                data_gnt_i,
  input lsu_pkg::lsu_addr_t  data_addr_o,
  input logic                data_we_o,
  input lsu_pkg::lsu_be_t    data_be_o,
  input lsu_pkg::lsu_data_t  data_wdata_o,
  input logic                lsu_resp_valid_o,
  input logic                busy_o
);

  int unsigned fail_count = 0;

  // bus address is a known whole word while requesting
  a_addr_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
      data_req_o |-> (!$isunknown(data_addr_o) && (data_addr_o[1:0] == 2'b00)))
    else begin
      $error("bus address not word-aligned or unknown during a request");
      fail_count++;
    end

  // back-pressure keeps the whole request on the bus
  a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (data_req_o && !data_gnt_i) |=> (data_req_o && $stable(data_addr_o) &&
      $stable(data_we_o) && $stable(data_be_o) && $stable(data_wdata_o)))
    else begin
      $error("bus request changed before its grant");
      fail_count++;
    end

  a_be_nonzero: assert property (@(posedge clk_i) disable iff (!rst_ni)
      data_req_o |-> (data_be_o != '0))
    else begin
      $error("bus request without byte enables");
      fail_count++;
    end

  // final response only ever lands in IDLE
  a_resp_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
      !(lsu_resp_valid_o && busy_o))
    else begin
      $error("response valid while the unit is busy");
      fail_count++;
    end

endmodule

`default_nettype wire

// ==== dv/lsu_tb.sv ====
//////////////////////////////
// directed tests for lsu_top against a byte-array bus model
// model memory is 1 KiB, addresses wrap on their low 10 bits
// grants take 0 to 2 cycles, responses 1 to 2 cycles after grant
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "lsu_config.svh"

module lsu_tb;
  import lsu_pkg::*;

  localparam int MEM_BYTES  = 1024;
  localparam int WAIT_LIMIT = 40;

  logic      clk_i = 1'b0;
  logic      rst_ni;
  logic      lsu_req_i, lsu_we_i, lsu_sign_ext_i;
  lsu_size_e lsu_size_i;
  lsu_addr_t lsu_addr_i, addr_last_o, data_addr_o;
  lsu_data_t lsu_wdata_i, lsu_rdata_o, data_wdata_o;
  logic      lsu_req_done_o, lsu_resp_valid_o, lsu_rdata_valid_o;
  logic      load_err_o, store_err_o, busy_o, data_req_o, data_we_o;
  lsu_be_t   data_be_o;
  logic      data_gnt_i;
  logic      data_rvalid_i  = 1'b0;
  logic      data_bus_err_i = 1'b0;
  lsu_data_t data_rdata_i   = '0;

  // bus model state
  logic [7:0]  mem [MEM_BYTES];
  logic [7:0]  shadow [MEM_BYTES];
  logic        gnt_ready = 1'b0;
  int          gnt_wait;
  int unsigned cyc, last_due, gnt_count;
  lsu_addr_t   fault_lo, fault_hi;
  int unsigned rsp_due[$];
  lsu_data_t   rsp_data[$];
  logic        rsp_err[$];

  // results of the last access, sampled at the response
  lsu_data_t   res_rdata;
  logic        res_rdata_valid, res_load_err, res_store_err, res_ok;
  int unsigned checks, errors, timeouts;

  always #10 clk_i = ~clk_i;

  lsu_top uut (.*);

  bind lsu_top lsu_checker u_checker (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .data_req_o       (data_req_o),
    .data_gnt_i       (data_gnt_i),
    .data_addr_o      (data_addr_o),
    .data_we_o        (data_we_o),
    .data_be_o        (data_be_o),
    .data_wdata_o     (data_wdata_o),
    .lsu_resp_valid_o (lsu_resp_valid_o),
    .busy_o           (busy_o)
  );

  ////////////////////////////////
  // bus model
  ////////////////////////////////

  // grant follows the request once the drawn delay has run out
  assign data_gnt_i = data_req_o & gnt_ready;

  function automatic logic in_fault(input lsu_addr_t word_addr);
    return (word_addr >= fault_lo) && (word_addr <= fault_hi);
  endfunction

  function automatic int size_bytes(input lsu_size_e size);
    return (size == WORD) ? 4 : ((size == HALF) ? 2 : 1);
  endfunction

  task automatic accept_request();
    int unsigned due;
    int          i;
    lsu_data_t   rd;
    logic        err;
    logic [9:0]  base;
    base = data_addr_o[9:0];
    err  = in_fault(data_addr_o);
    gnt_count++;
    for (i = 0; i < 4; i++) begin
      if (data_we_o && data_be_o[i] && !err) begin
        mem[base + 10'(i)] = data_wdata_o[8*i +: 8];
      end
      rd[8*i +: 8] = mem[base + 10'(i)];
    end
    if (err) begin
      rd = 32'hdead_beef;
    end
    // in order, at most one response per cycle
    due = cyc + $urandom_range(1);
    if (due <= last_due) begin
      due = last_due + 1;
    end
    last_due = due;
    rsp_due.push_back(due);
    rsp_data.push_back(rd);
    rsp_err.push_back(err);
    gnt_wait = $urandom_range(2);
    gnt_ready <= (gnt_wait == 0);
  endtask

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      gnt_ready      <= 1'b0;
      gnt_wait       = 1;
      data_rvalid_i  <= 1'b0;
      data_bus_err_i <= 1'b0;
      rsp_due.delete();
      rsp_data.delete();
      rsp_err.delete();
    end else begin
      cyc = cyc + 1;
      if (data_req_o && data_gnt_i) begin
        accept_request();
      end else if (data_req_o && !gnt_ready) begin
        if (gnt_wait > 0) begin
          gnt_wait = gnt_wait - 1;
        end
        if (gnt_wait == 0) begin
          gnt_ready <= 1'b1;
        end
      end
      data_rvalid_i  <= 1'b0;
      data_bus_err_i <= 1'b0;
      if ((rsp_due.size() > 0) && (rsp_due[0] == cyc)) begin
        data_rvalid_i  <= 1'b1;
        data_bus_err_i <= rsp_err.pop_front();
        data_rdata_i   <= rsp_data.pop_front();
        void'(rsp_due.pop_front());
      end
    end
  end

  ////////////////////////////////
  // core side and checks
  ////////////////////////////////

  task automatic check_value(input string name, input lsu_data_t exp, input lsu_data_t got);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("** Error [%s] expected %h, got %h", name, exp, got);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic got);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("** Error [%s] expected %b, got %b", name, exp, got);
    end
  endtask

  // little-endian bytes from the shadow, then zero or sign extension
  function automatic lsu_data_t expect_load(input lsu_size_e size, input logic sext,
                                            input lsu_addr_t addr);
    int        i;
    int        nbytes;
    lsu_data_t v;
    lsu_addr_t a;
    nbytes = size_bytes(size);
    v      = '0;
    for (i = 0; i < nbytes; i++) begin
      a = addr + lsu_addr_t'(i);
      v[8*i +: 8] = shadow[a[9:0]];
    end
    if (sext && (nbytes < 4) && v[8*nbytes-1]) begin
      v = v | ~((lsu_data_t'(1) << (8 * nbytes)) - lsu_data_t'(1));
    end
    return v;
  endfunction

  // bytes of a faulting word are never written
  task automatic shadow_store(input lsu_size_e size, input lsu_addr_t addr,
                              input lsu_data_t wdata);
    int        i;
    lsu_addr_t a;
    for (i = 0; i < size_bytes(size); i++) begin
      a = addr + lsu_addr_t'(i);
      if (!in_fault({a[31:2], 2'b00})) begin
        shadow[a[9:0]] = wdata[8*i +: 8];
      end
    end
  endtask

  task automatic run_access(input string name, input logic we, input lsu_size_e size,
                            input logic sext, input lsu_addr_t addr, input lsu_data_t wdata);
    int   n;
    logic seen;
    res_ok = 1'b0;
    @(posedge clk_i);
    lsu_req_i      <= 1'b1;
    lsu_we_i       <= we;
    lsu_size_i     <= size;
    lsu_sign_ext_i <= sext;
    lsu_addr_i     <= addr;
    lsu_wdata_i    <= wdata;
    n = 0;
    @(negedge clk_i);
    while (!lsu_req_done_o && (n < WAIT_LIMIT)) begin
      @(negedge clk_i);
      n++;
    end
    seen = lsu_req_done_o;
    // request is dropped after the done cycle
    @(posedge clk_i);
    lsu_req_i <= 1'b0;
    if (!seen) begin
      timeouts++;
      $display("timeout: %s got no lsu_req_done_o within %0d cycles", name, WAIT_LIMIT);
    end else begin
      n = 0;
      @(negedge clk_i);
      while (!lsu_resp_valid_o && (n < WAIT_LIMIT)) begin
        @(negedge clk_i);
        n++;
      end
      if (!lsu_resp_valid_o) begin
        timeouts++;
        $display("timeout: %s got no lsu_resp_valid_o within %0d cycles", name, WAIT_LIMIT);
      end else begin
        res_rdata       = lsu_rdata_o;
        res_rdata_valid = lsu_rdata_valid_o;
        res_load_err    = load_err_o;
        res_store_err   = store_err_o;
        res_ok          = 1'b1;
      end
    end
  endtask

  task automatic do_store(input string name, input lsu_size_e size, input lsu_addr_t addr,
                          input lsu_data_t wdata);
    run_access(name, 1'b1, size, 1'b0, addr, wdata);
    shadow_store(size, addr, wdata);
    if (res_ok) begin
      check_flag({name, " store_err"}, 1'b0, res_store_err);
      check_flag({name, " rdata_valid"}, 1'b0, res_rdata_valid);
    end
  endtask

  task automatic do_load(input string name, input lsu_size_e size, input logic sext,
                         input lsu_addr_t addr);
    lsu_data_t exp;
    exp = expect_load(size, sext, addr);
    run_access(name, 1'b0, size, sext, addr, '0);
    if (res_ok) begin
      check_value(name, exp, res_rdata);
      check_flag({name, " rdata_valid"}, 1'b1, res_rdata_valid);
      check_flag({name, " load_err"}, 1'b0, res_load_err);
    end
  endtask

  // error response, addr_last_o must hold the trap value
  task automatic check_fault(input string name, input logic we, input lsu_size_e size,
                             input lsu_addr_t addr, input lsu_addr_t exp_last);
    run_access(name, we, size, 1'b0, addr, 32'h5a5a_a5a5);
    if (we) begin
      shadow_store(size, addr, 32'h5a5a_a5a5);
    end
    if (res_ok) begin
      check_flag({name, " load_err"}, ~we, res_load_err);
      check_flag({name, " store_err"}, we, res_store_err);
      check_flag({name, " rdata_valid"}, 1'b0, res_rdata_valid);
      check_value({name, " addr_last"}, exp_last, addr_last_o);
    end
  endtask

  task automatic check_mem_word(input string name, input lsu_addr_t addr, input lsu_data_t exp);
    int        i;
    lsu_addr_t a;
    for (i = 0; i < 4; i++) begin
      a = addr + lsu_addr_t'(i);
      check_value(name, {24'h0, exp[8*i +: 8]}, {24'h0, mem[a[9:0]]});
    end
  endtask

  ////////////////////////////////
  // directed tests
  ////////////////////////////////

  // status and bus outputs right after reset, no request pending
  task automatic test_reset_values();
    @(negedge clk_i);
    check_flag("reset data_req", 1'b0, data_req_o);
    check_flag("reset req_done", 1'b0, lsu_req_done_o);
    check_flag("reset resp_valid", 1'b0, lsu_resp_valid_o);
    check_flag("reset rdata_valid", 1'b0, lsu_rdata_valid_o);
    check_flag("reset load_err", 1'b0, load_err_o);
    check_flag("reset store_err", 1'b0, store_err_o);
    check_flag("reset busy", 1'b0, busy_o);
    check_value("reset addr_last", '0, addr_last_o);
  endtask

  task automatic test_aligned_word();
    do_store("aligned store", WORD, 32'h40, 32'hcafe_f00d);
    check_mem_word("aligned store mem", 32'h40, 32'hcafe_f00d);
    do_load("aligned load", WORD, 1'b0, 32'h40);
  endtask

  task automatic test_narrow_loads();
    int off;
    int s;
    // sign bits set and clear across the lanes
    do_store("narrow setup lo", WORD, 32'h80, 32'hf17f_80e5);
    do_store("narrow setup hi", WORD, 32'h84, 32'h0a9b_6c8d);
    for (off = 0; off < 4; off++) begin
      for (s = 0; s < 2; s++) begin
        do_load($sformatf("byte off %0d sext %0d", off, s), BYTE, s[0], 32'h80 + off);
        do_load($sformatf("half off %0d sext %0d", off, s), HALF, s[0], 32'h80 + off);
      end
    end
  endtask

  task automatic test_misaligned_word();
    int          off;
    int unsigned g0;
    lsu_addr_t   a;
    for (off = 1; off < 4; off++) begin
      a  = lsu_addr_t'(32'h100 + 16 * off + off);
      g0 = gnt_count;
      do_store($sformatf("mis store off %0d", off), WORD, a, 32'h1234_5678 + off);
      check_value($sformatf("mis store grants %0d", off), 32'd2, gnt_count - g0);
      check_mem_word($sformatf("mis store mem %0d", off), a, 32'h1234_5678 + off);
      g0 = gnt_count;
      do_load($sformatf("mis load off %0d", off), WORD, 1'b0, a);
      check_value($sformatf("mis load grants %0d", off), 32'd2, gnt_count - g0);
    end
  endtask

  task automatic test_half_split();
    int          off;
    int unsigned g0;
    g0 = gnt_count;
    do_store("half split store", HALF, 32'h143, 32'h0000_b77e);
    check_value("half split store grants", 32'd2, gnt_count - g0);
    g0 = gnt_count;
    do_load("half split load", HALF, 1'b1, 32'h143);
    check_value("half split load grants", 32'd2, gnt_count - g0);
    for (off = 0; off < 3; off++) begin
      g0 = gnt_count;
      do_store($sformatf("half store off %0d", off), HALF, 32'h150 + off, 32'h8421 + off);
      do_load($sformatf("half load off %0d", off), HALF, 1'b0, 32'h150 + off);
      check_value($sformatf("half grants off %0d", off), 32'd2, gnt_count - g0);
    end
  endtask

  task automatic test_bus_errors();
    fault_lo = 32'h200;
    fault_hi = 32'h200;
    // first half faults, original address is kept
    check_fault("err load first half", 1'b0, WORD, 32'h202, 32'h202);
    check_fault("err store first half", 1'b1, HALF, 32'h203, 32'h203);
    // second half faults, aligned second word is kept
    check_fault("err load second half", 1'b0, WORD, 32'h1fe, 32'h200);
    check_fault("err store second half", 1'b1, WORD, 32'h1fd, 32'h200);
    check_fault("err load single", 1'b0, BYTE, 32'h201, 32'h201);
    fault_lo = '1;
    fault_hi = '0;
    do_load("err recovery load", HALF, 1'b0, 32'h203);
  endtask

  task automatic test_random_mix();
    int        n;
    lsu_size_e size;
    lsu_addr_t addr;
    lsu_data_t wdata;
    logic      we;
    logic      sext;
    for (n = 0; n < 200; n++) begin
      // size 3 is the unnamed byte encoding
      size  = lsu_size_e'($urandom_range(3));
      addr  = lsu_addr_t'(32'h300 + 4 * $urandom_range(60) + $urandom_range(3));
      we    = 1'($urandom_range(1));
      sext  = 1'($urandom_range(1));
      wdata = $urandom();
      if (we) begin
        do_store($sformatf("random store %0d", n), size, addr, wdata);
      end else begin
        do_load($sformatf("random load %0d", n), size, sext, addr);
      end
    end
  endtask

  initial begin
    int          i;
    int unsigned fails;
    void'($urandom(32'h4896));
    rst_ni         = 1'b0;
    lsu_req_i      = 1'b0;
    lsu_we_i       = 1'b0;
    lsu_size_i     = WORD;
    lsu_sign_ext_i = 1'b0;
    lsu_addr_i     = '0;
    lsu_wdata_i    = '0;
    fault_lo       = '1;
    fault_hi       = '0;
    // fill covers all ten index bits
    for (i = 0; i < MEM_BYTES; i++) begin
      mem[i]    = 8'((i * 29) ^ (i >> 3));
      shadow[i] = 8'((i * 29) ^ (i >> 3));
    end
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    test_reset_values();
    test_aligned_word();
    test_narrow_loads();
    test_misaligned_word();
    test_half_split();
    test_bus_errors();
    test_random_mix();
    @(posedge clk_i);
    fails = errors + timeouts + uut.u_checker.fail_count;
    $display("checks: %0d  errors: %0d  timeouts: %0d  assertion failures: %0d",
             checks, errors, timeouts, uut.u_checker.fail_count);
    if (fails == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+include
source/lsu_pkg.sv
source/lsu_addr_gen.sv
source/lsu_store_align.sv
source/lsu_load_align.sv
source/lsu_ctrl_fsm.sv
source/lsu_top.sv
dv/lsu_checker.sv
dv/lsu_tb.sv

// ==== include/lsu_config.svh ====
//////////////////////////////
// width settings for the load/store unit
// the data path assumes one 32-bit word with four byte lanes
//////////////////////////////

`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// byte address, one word wide
`define LSU_ADDR_W 32

// bus and register data word
`define LSU_DATA_W 32

// byte lanes per data word
`define LSU_BE_W 4

// byte offset inside a word, log2 of the lane count
`define LSU_OFFSET_W 2

`endif

// ==== source/lsu_addr_gen.sv ====
//////////////////////////////
// second-half address is the held last address plus one word
// addr_last_o is not updated after an error, it keeps the trap value
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "lsu_config.svh"

module lsu_addr_gen (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  lsu_pkg::lsu_addr_t lsu_addr_i,
  input  logic               second_half_i,
  input  logic               addr_update_i,
  output lsu_pkg::lsu_addr_t data_addr_o,
  output lsu_pkg::lsu_addr_t addr_last_o
);
  import lsu_pkg::*;

  lsu_addr_t addr_last_q;
  lsu_addr_t addr_last_d;
  lsu_addr_t data_addr;

  // current access address
  // in the second half the low offset bits still match the core address
  assign data_addr = second_half_i ? addr_last_q + lsu_addr_t'(`LSU_BE_W) : lsu_addr_i;

  // first part keeps the unaligned address, second part the aligned word
  assign addr_last_d = second_half_i ?
      {data_addr[`LSU_ADDR_W-1:`LSU_OFFSET_W], {`LSU_OFFSET_W{1'b0}}} : data_addr;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_last_q <= '0;
    end else if (addr_update_i) begin
      addr_last_q <= addr_last_d;
    end
  end

  assign data_addr_o = data_addr;
  assign addr_last_o = addr_last_q;

endmodule

`default_nettype wire

// ==== source/lsu_ctrl_fsm.sv ====
//////////////////////////////
// bus request FSM with split handling and error merge
// at most two bus requests are outstanding, responses arrive in order
// the core holds its request until lsu_req_done_o
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "lsu_config.svh"

module lsu_ctrl_fsm (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               lsu_req_i,
  input  lsu_pkg::lsu_size_e lsu_size_i,
  input  lsu_pkg::lsu_addr_t data_addr_i,
  input  logic               data_gnt_i,
  input  logic               data_rvalid_i,
  input  logic               data_bus_err_i,
  input  logic               we_q_i,
  output logic               data_req_o,
  output logic               second_half_o,
  output logic               ctrl_update_o,
  output logic               rdata_update_o,
  output logic               addr_update_o,
  output logic               lsu_req_done_o,
  output logic               lsu_resp_valid_o,
  output logic               lsu_rdata_valid_o,
  output logic               load_err_o,
  output logic               store_err_o,
  output logic               busy_o
);
  import lsu_pkg::*;

  lsu_offset_t offset;
  logic        split_access;
  lsu_state_e  state_q;
  lsu_state_e  state_d;
  // high from the first grant until the second half is granted
  logic        handle_mis_q;
  logic        handle_mis_d;
  // bus error of the first half, merged into the final response
  logic        lsu_err_q;
  logic        lsu_err_d;
  logic        resp_err;

  assign offset = data_addr_i[`LSU_OFFSET_W-1:0];

  // word off its boundary, or a halfword in the top lane
  assign split_access = ((lsu_size_i == WORD) && (offset != '0)) ||
                        ((lsu_size_i == HALF) && (offset == lsu_offset_t'(3)));

  ////////////////////////////////
  // next state
  ////////////////////////////////

  always_comb begin
    state_d        = state_q;
    handle_mis_d   = handle_mis_q;
    lsu_err_d      = lsu_err_q;
    data_req_o     = 1'b0;
    second_half_o  = 1'b0;
    ctrl_update_o  = 1'b0;
    rdata_update_o = 1'b0;
    addr_update_o  = 1'b0;

    unique case (state_q)
      IDLE: begin
        if (lsu_req_i) begin
          data_req_o = 1'b1;
          lsu_err_d  = 1'b0;
          if (data_gnt_i) begin
            ctrl_update_o = 1'b1;
            addr_update_o = 1'b1;
            handle_mis_d  = split_access;
            state_d       = split_access ? WAIT_RVALID_MIS : IDLE;
          end else begin
            state_d       = split_access ? WAIT_GNT_MIS : WAIT_GNT;
          end
        end
      end

      // first half still waiting for its grant
      WAIT_GNT_MIS: begin
        data_req_o = 1'b1;
        if (data_gnt_i) begin
          ctrl_update_o = 1'b1;
          addr_update_o = 1'b1;
          handle_mis_d  = 1'b1;
          state_d       = WAIT_RVALID_MIS;
        end
      end

      // second request goes out while the first response is pending
      WAIT_RVALID_MIS: begin
        data_req_o    = 1'b1;
        second_half_o = 1'b1;
        if (data_rvalid_i) begin
          lsu_err_d      = data_bus_err_i;
          rdata_update_o = ~we_q_i;
          // keep the first-half address as trap value on an error
          addr_update_o  = data_gnt_i & ~data_bus_err_i;
          handle_mis_d   = ~data_gnt_i;
          state_d        = data_gnt_i ? IDLE : WAIT_GNT;
        end else if (data_gnt_i) begin
          handle_mis_d = 1'b0;
          state_d      = WAIT_RVALID_MIS_GNTS_DONE;
        end
      end

      // single access, or second half once the first response is in
      WAIT_GNT: begin
        data_req_o    = 1'b1;
        second_half_o = handle_mis_q;
        if (data_gnt_i) begin
          ctrl_update_o = 1'b1;
          addr_update_o = ~lsu_err_q;
          handle_mis_d  = 1'b0;
          state_d       = IDLE;
        end
      end

      // both grants done, first response still pending
      // second_half_o stays up so the aligned second address is stored
      WAIT_RVALID_MIS_GNTS_DONE: begin
        second_half_o = 1'b1;
        if (data_rvalid_i) begin
          lsu_err_d      = data_bus_err_i;
          addr_update_o  = ~data_bus_err_i;
          rdata_update_o = ~we_q_i;
          state_d        = IDLE;
        end
      end

      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= IDLE;
      handle_mis_q <= 1'b0;
      lsu_err_q    <= 1'b0;
    end else begin
      state_q      <= state_d;
      handle_mis_q <= handle_mis_d;
      lsu_err_q    <= lsu_err_d;
    end
  end

  ////////////////////////////////
  // core-side status
  ////////////////////////////////

  // all bus requests of the access granted, only responses remain
  assign lsu_req_done_o = (lsu_req_i | (state_q != IDLE)) & (state_d == IDLE);

  // final response always lands in IDLE
  assign lsu_resp_valid_o  = data_rvalid_i & (state_q == IDLE);
  assign resp_err          = lsu_err_q | data_bus_err_i;
  assign lsu_rdata_valid_o = lsu_resp_valid_o & ~resp_err & ~we_q_i;

  // error class follows the direction of the outstanding access
  assign load_err_o  = lsu_resp_valid_o & resp_err & ~we_q_i;
  assign store_err_o = lsu_resp_valid_o & resp_err & we_q_i;

  assign busy_o = (state_q != IDLE);

endmodule

`default_nettype wire

// ==== source/lsu_load_align.sv ====
//////////////////////////////
// load data realignment and extension
// output is combinational on data_rdata_i, valid only with the final rvalid
// access controls are sampled on each grant
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "lsu_config.svh"

module lsu_load_align (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               ctrl_update_i,
  input  logic               rdata_update_i,
  input  lsu_pkg::lsu_addr_t data_addr_i,
  input  lsu_pkg::lsu_size_e lsu_size_i,
  input  logic               lsu_sign_ext_i,
  input  logic               lsu_we_i,
  input  lsu_pkg::lsu_data_t data_rdata_i,
  output logic               we_q_o,
  output lsu_pkg::lsu_data_t lsu_rdata_o
);
  import lsu_pkg::*;

  lsu_offset_t              offset_q;
  lsu_size_e                size_q;
  logic                     sign_ext_q;
  logic                     we_q;
  // upper three bytes of the first response
  logic [`LSU_DATA_W-9:0]   rdata_q;
  logic                     split_q;
  logic [2*`LSU_DATA_W-1:0] rdata_window;
  lsu_data_t                rdata_aligned;
  lsu_data_t                rdata_ext;

  ////////////////////////////////
  // access registers
  ////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      offset_q   <= '0;
      size_q     <= WORD;
      sign_ext_q <= 1'b0;
      we_q       <= 1'b0;
    end else if (ctrl_update_i) begin
      offset_q   <= data_addr_i[`LSU_OFFSET_W-1:0];
      size_q     <= lsu_size_i;
      sign_ext_q <= lsu_sign_ext_i;
      we_q       <= lsu_we_i;
    end
  end

  // lane 0 of the first word is never part of a split load
  always_ff @(posedge clk_i) begin
    if (rdata_update_i) begin
      rdata_q <= data_rdata_i[`LSU_DATA_W-1:8];
    end
  end

  ////////////////////////////////
  // realignment
  ////////////////////////////////

  // same split rule as the FSM, on the sampled controls
  assign split_q = ((size_q == WORD) && (offset_q != '0)) ||
                   ((size_q == HALF) && (offset_q == lsu_offset_t'(3)));

  // first word below, second response above
  // a split access starts at the offset inside the first word
  assign rdata_window = {data_rdata_i, rdata_q, 8'h00};

  always_comb begin
    if (split_q) begin
      rdata_aligned = rdata_window[{offset_q, 3'b000} +: `LSU_DATA_W];
    end else begin
      rdata_aligned = data_rdata_i >> {offset_q, 3'b000};
    end
  end

  // zero or sign extension by size
  always_comb begin
    case (size_q)
      WORD: begin
        rdata_ext = rdata_aligned;
      end
      HALF: begin
        rdata_ext = {{16{sign_ext_q & rdata_aligned[15]}}, rdata_aligned[15:0]};
      end
      default: begin
        rdata_ext = {{24{sign_ext_q & rdata_aligned[7]}}, rdata_aligned[7:0]};
      end
    endcase
  end

  assign lsu_rdata_o = rdata_ext;
  // direction of the outstanding access
  assign we_q_o      = we_q;

endmodule

`default_nettype wire

// ==== source/lsu_pkg.sv ====
//////////////////////////////
// shared types of the load/store unit
// widths come from lsu_config.svh
//////////////////////////////

`default_nettype none

`include "lsu_config.svh"

package lsu_pkg;

  // address, data and lane vectors
  typedef logic [`LSU_ADDR_W-1:0]   lsu_addr_t;
  typedef logic [`LSU_DATA_W-1:0]   lsu_data_t;
  typedef logic [`LSU_BE_W-1:0]     lsu_be_t;
  typedef logic [`LSU_OFFSET_W-1:0] lsu_offset_t;

  // access size from the execute stage
  // 2'b11 is not named but decodes as a byte access everywhere
  typedef enum logic [1:0] {
    WORD = 2'b00,
    HALF = 2'b01,
    BYTE = 2'b10
  } lsu_size_e;

  // bus request FSM
  // the *_MIS states belong to the first half of a split access
  typedef enum logic [2:0] {
    IDLE,
    WAIT_GNT_MIS,
    WAIT_RVALID_MIS,
    WAIT_GNT,
    WAIT_RVALID_MIS_GNTS_DONE
  } lsu_state_e;

endpackage

`default_nettype wire

// ==== source/lsu_store_align.sv ====
//////////////////////////////
// byte enables and store lane rotation, purely combinational
// a second half only gets the lanes that spill past the word boundary
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "lsu_config.svh"

module lsu_store_align (
  input  lsu_pkg::lsu_size_e lsu_size_i,
  input  lsu_pkg::lsu_addr_t data_addr_i,
  input  logic               second_half_i,
  input  lsu_pkg::lsu_data_t lsu_wdata_i,
  output lsu_pkg::lsu_be_t   data_be_o,
  output lsu_pkg::lsu_data_t data_wdata_o
);
  import lsu_pkg::*;

  lsu_offset_t                 offset;
  lsu_be_t                     size_mask;
  logic [2*`LSU_BE_W-1:0]      be_span;
  logic [2*`LSU_DATA_W-1:0]    wdata_dbl;

  assign offset = data_addr_i[`LSU_OFFSET_W-1:0];

  ////////////////////////////////
  // byte enables
  ////////////////////////////////

  // lanes covered by the access when it starts at lane 0
  always_comb begin
    case (lsu_size_i)
      WORD:    size_mask = '1;
      HALF:    size_mask = lsu_be_t'(4'b0011);
      // BYTE and the unnamed encoding
      default: size_mask = lsu_be_t'(4'b0001);
    endcase
  end

  // shift over two words
  // low word goes to the first access, high word to the second
  assign be_span = {{`LSU_BE_W{1'b0}}, size_mask} << offset;

  assign data_be_o = second_half_i ? be_span[2*`LSU_BE_W-1:`LSU_BE_W] :
                                     be_span[`LSU_BE_W-1:0];

  ////////////////////////////////
  // write data
  ////////////////////////////////

  // rotate left by offset bytes
  // the same word then serves both halves, each with its own enables
  assign wdata_dbl    = {lsu_wdata_i, lsu_wdata_i} << {offset, 3'b000};
  assign data_wdata_o = wdata_dbl[2*`LSU_DATA_W-1:`LSU_DATA_W];

endmodule

`default_nettype wire

// ==== source/lsu_top.sv ====
//////////////////////////////
// load/store unit top, one access at a time
// split accesses issue two word-aligned bus requests
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "lsu_config.svh"

module lsu_top (
  input  logic               clk_i,
  input  logic               rst_ni,

  // core side
  input  logic               lsu_req_i,
  input  logic               lsu_we_i,
  input  lsu_pkg::lsu_size_e lsu_size_i,
  input  logic               lsu_sign_ext_i,
  input  lsu_pkg::lsu_addr_t lsu_addr_i,
  input  lsu_pkg::lsu_data_t lsu_wdata_i,
  output logic               lsu_req_done_o,
  output logic               lsu_resp_valid_o,
  output lsu_pkg::lsu_data_t lsu_rdata_o,
  output logic               lsu_rdata_valid_o,
  output logic               load_err_o,
  output logic               store_err_o,
  output lsu_pkg::lsu_addr_t addr_last_o,
  output logic               busy_o,

  // data bus
  output logic               data_req_o,
  input  logic               data_gnt_i,
  input  logic               data_rvalid_i,
  input  logic               data_bus_err_i,
  output lsu_pkg::lsu_addr_t data_addr_o,
  output logic               data_we_o,
  output lsu_pkg::lsu_be_t   data_be_o,
  output lsu_pkg::lsu_data_t data_wdata_o,
  input  lsu_pkg::lsu_data_t data_rdata_i
);
  import lsu_pkg::*;

  logic      second_half;
  logic      ctrl_update;
  logic      rdata_update;
  logic      addr_update;
  logic      we_q;
  // unaligned address of the current part
  lsu_addr_t data_addr;

  lsu_addr_gen u_addr_gen (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .lsu_addr_i    (lsu_addr_i),
    .second_half_i (second_half),
    .addr_update_i (addr_update),
    .data_addr_o   (data_addr),
    .addr_last_o   (addr_last_o)
  );

  lsu_store_align u_store_align (
    .lsu_size_i    (lsu_size_i),
    .data_addr_i   (data_addr),
    .second_half_i (second_half),
    .lsu_wdata_i   (lsu_wdata_i),
    .data_be_o     (data_be_o),
    .data_wdata_o  (data_wdata_o)
  );

  lsu_load_align u_load_align (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .ctrl_update_i  (ctrl_update),
    .rdata_update_i (rdata_update),
    .data_addr_i    (data_addr),
    .lsu_size_i     (lsu_size_i),
    .lsu_sign_ext_i (lsu_sign_ext_i),
    .lsu_we_i       (lsu_we_i),
    .data_rdata_i   (data_rdata_i),
    .we_q_o         (we_q),
    .lsu_rdata_o    (lsu_rdata_o)
  );

  lsu_ctrl_fsm u_ctrl_fsm (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .lsu_req_i         (lsu_req_i),
    .lsu_size_i        (lsu_size_i),
    .data_addr_i       (data_addr),
    .data_gnt_i        (data_gnt_i),
    .data_rvalid_i     (data_rvalid_i),
    .data_bus_err_i    (data_bus_err_i),
    .we_q_i            (we_q),
    .data_req_o        (data_req_o),
    .second_half_o     (second_half),
    .ctrl_update_o     (ctrl_update),
    .rdata_update_o    (rdata_update),
    .addr_update_o     (addr_update),
    .lsu_req_done_o    (lsu_req_done_o),
    .lsu_resp_valid_o  (lsu_resp_valid_o),
    .lsu_rdata_valid_o (lsu_rdata_valid_o),
    .load_err_o        (load_err_o),
    .store_err_o       (store_err_o),
    .busy_o            (busy_o)
  );

  // bus sees whole words only
  assign data_addr_o = {data_addr[`LSU_ADDR_W-1:`LSU_OFFSET_W], {`LSU_OFFSET_W{1'b0}}};
  assign data_we_o   = lsu_we_i;

endmodule

`default_nettype wire
